//--- logic/fetch_defines.svh
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// ##########################################################
// L1 instruction cache geometry
// ##########################################################
`define L1I_SETS       4  // Direct mapped.
`define L1I_LINE_WORDS 2
`define L1I_IDX_W      2
`define L1I_OFS_W      1

// ##########################################################
// Fetch constants
// ##########################################################
`define PC_INIT 32'h8000_0000

`define OP_JAL    7'b1101111
`define OP_JALR   7'b1100111
`define OP_BRANCH 7'b1100011
`define OP_SYSTEM 7'b1110011
`define OP_LOAD   7'b0000011

`define INST_FENCE_I 32'h0000_100f

`endif

//--- logic/fetch_types_pkg.sv
`default_nettype none

`include "fetch_defines.svh"

package fetch_types_pkg;

  typedef logic [31:0] addr_t;  // Byte address.
  typedef logic [31:0] inst_t;

  // Address bits above set index, word offset and byte offset.
  typedef logic [31-`L1I_IDX_W-`L1I_OFS_W-2:0] tag_t;
  typedef logic [`L1I_IDX_W-1:0] idx_t;
  typedef logic [`L1I_OFS_W-1:0] ofs_t;

  typedef enum logic [1:0] {
    IDLE,
    REQ0,  // Even word of the line.
    REQ1,  // Odd word of the line.
    DONE
  } refill_state_e;

  typedef enum logic [1:0] {
    NONE,
    SPEC,
    GOOD,
    BAD
  } spec_state_e;

endpackage

`default_nettype wire

//--- logic/fetch_bus_pkg.sv
`default_nettype none

package fetch_bus_pkg;
  import fetch_types_pkg::*;

  typedef struct packed {
    logic  valid;
    addr_t addr;  // Word aligned.
  } mem_req_t;

  typedef struct packed {
    logic  valid;  // One cycle pulse.
    inst_t data;
  } mem_resp_t;

  typedef struct packed {
    logic  change;  // Resolved to target.
    logic  retire;  // Resolved to pc plus 4.
    addr_t target;
    addr_t pc;
  } commit_t;

  typedef struct packed {
    logic  we;
    idx_t  idx;
    ofs_t  ofs;
    tag_t  tag;
    inst_t data;
    logic  last;  // Sets the line valid.
  } line_wr_t;

  typedef struct packed {
    inst_t inst;
    addr_t pc;
  } fetch_bundle_t;

endpackage

`default_nettype wire

//--- logic/l1i_refill.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defines.svh"

module l1i_refill
  import fetch_types_pkg::*;
  import fetch_bus_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      refill_start_i,
  input  addr_t     refill_pc_i,
  output mem_req_t  mem_req_o,
  input  mem_resp_t mem_resp_i,
  output line_wr_t  line_wr_o,
  output logic      refill_done_o
);

  refill_state_e state_q;
  addr_t         refill_pc_q;
  logic          req_valid_q;
  ofs_t          req_ofs;
  logic          resp_ok;

  assign req_ofs       = ofs_t'(state_q == REQ1);
  assign resp_ok       = req_valid_q && mem_resp_i.valid;
  assign refill_done_o = (state_q == DONE);

  always_comb begin
    mem_req_o.valid = req_valid_q;
    mem_req_o.addr  = {refill_pc_q[31:`L1I_OFS_W+2], req_ofs, 2'b00};
  end

  // Each returned word goes straight into the array.
  always_comb begin
    line_wr_o.we   = resp_ok;
    line_wr_o.idx  = refill_pc_q[`L1I_OFS_W+2 +: `L1I_IDX_W];
    line_wr_o.ofs  = req_ofs;
    line_wr_o.tag  = refill_pc_q[31 -: $bits(tag_t)];
    line_wr_o.data = mem_resp_i.data;
    line_wr_o.last = (state_q == REQ1);
  end

  // ##########################################################
  // Bus state machine
  // ##########################################################
  always_ff @(posedge clk) begin
    if (rst) begin
      state_q     <= IDLE;
      req_valid_q <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          if (refill_start_i) begin
            state_q     <= REQ0;
            req_valid_q <= 1'b1;
          end
        end
        REQ0: begin
          if (resp_ok) begin
            state_q     <= REQ1;
            req_valid_q <= 1'b0;  // Drop for one cycle.
          end
        end
        REQ1: begin
          if (!req_valid_q) begin
            req_valid_q <= 1'b1;
          end else if (mem_resp_i.valid) begin
            state_q     <= DONE;
            req_valid_q <= 1'b0;
          end
        end
        default: begin
          state_q <= IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if ((state_q == IDLE) && refill_start_i) begin
      refill_pc_q <= refill_pc_i;
    end
  end

  a_req_stable: assert property (@(posedge clk) disable iff (rst)
    mem_req_o.valid && !mem_resp_i.valid |=> mem_req_o.valid && $stable(mem_req_o.addr));

endmodule

`default_nettype wire

//--- logic/l1i_array.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defines.svh"

module l1i_array
  import fetch_types_pkg::*;
  import fetch_bus_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  addr_t    lookup_pc_i,
  output logic     hit_o,
  output inst_t    rd_inst_o,
  input  line_wr_t line_wr_i,
  input  logic     invalidate_i
);

  tag_t  tag_mem  [`L1I_SETS][`L1I_LINE_WORDS];  // Tag per word.
  inst_t data_mem [`L1I_SETS][`L1I_LINE_WORDS];
  logic [`L1I_SETS-1:0] valid_q;

  idx_t lookup_idx;
  ofs_t lookup_ofs;
  tag_t lookup_tag;

  assign lookup_idx = lookup_pc_i[`L1I_OFS_W+2 +: `L1I_IDX_W];
  assign lookup_ofs = lookup_pc_i[2 +: `L1I_OFS_W];
  assign lookup_tag = lookup_pc_i[31 -: $bits(tag_t)];

  assign hit_o     = valid_q[lookup_idx] && (tag_mem[lookup_idx][lookup_ofs] == lookup_tag);
  assign rd_inst_o = data_mem[lookup_idx][lookup_ofs];

  always_ff @(posedge clk) begin
    if (line_wr_i.we) begin
      tag_mem[line_wr_i.idx][line_wr_i.ofs]  <= line_wr_i.tag;
      data_mem[line_wr_i.idx][line_wr_i.ofs] <= line_wr_i.data;
    end
  end

  // A fence.i clears every line valid bit.
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else if (invalidate_i) begin
      valid_q <= '0;
    end else if (line_wr_i.we && line_wr_i.last) begin
      valid_q[line_wr_i.idx] <= 1'b1;
    end
  end

  // The fetch side holds off refills until a pending fence.i has left.
  a_no_inval_fill: assert property (@(posedge clk) disable iff (rst)
    !(invalidate_i && line_wr_i.we && line_wr_i.last));

endmodule

`default_nettype wire

//--- logic/fetch_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defines.svh"

module fetch_ctrl
  import fetch_types_pkg::*;
  import fetch_bus_pkg::*;
(
  input  logic          clk,
  input  logic          rst,
  input  logic          hit_i,
  input  inst_t         rd_inst_i,
  output logic          refill_start_o,
  output addr_t         refill_pc_o,
  input  logic          refill_done_i,
  output addr_t         lookup_pc_o,
  output logic          take_o,
  output fetch_bundle_t take_bundle_o,
  input  logic          out_free_i,
  input  commit_t       commit_i,
  output logic          spec_o,
  output logic          good_spec_o,
  output logic          bad_spec_o
);

  addr_t       pc_q;
  logic        stall_q;
  logic        refilling_q;
  logic        fence_pend_q;
  addr_t       btb_q;
  logic        btb_valid_q;
  spec_state_e spec_state_q;
  addr_t       spec_target_q;
  addr_t       redirect_q;

  logic [6:0] opcode;
  logic       is_load;
  logic       is_ctrl;
  logic       is_fence_i;
  logic       can_fetch;
  logic       commit_any;
  addr_t      resolved_pc;
  logic       spec_match;

  assign opcode     = rd_inst_i[6:0];
  assign is_load    = (opcode == `OP_LOAD);
  assign is_ctrl    = (opcode == `OP_JAL) || (opcode == `OP_JALR) ||
                      (opcode == `OP_BRANCH) || (opcode == `OP_SYSTEM);
  assign is_fence_i = (rd_inst_i == `INST_FENCE_I);

  assign commit_any  = commit_i.change || commit_i.retire;
  assign resolved_pc = commit_i.change ? commit_i.target : commit_i.pc + 32'd4;
  assign spec_match  = (resolved_pc == spec_target_q);

  assign can_fetch      = !stall_q && !refilling_q && !fence_pend_q && (spec_state_q != BAD);
  assign take_o         = can_fetch && out_free_i && hit_i;
  assign refill_start_o = can_fetch && out_free_i && !hit_i;  // Only with room downstream.
  assign refill_pc_o    = pc_q;
  assign lookup_pc_o    = pc_q;

  assign take_bundle_o = '{inst: rd_inst_i, pc: pc_q};

  assign spec_o      = (spec_state_q == SPEC);
  assign good_spec_o = (spec_state_q == GOOD);
  assign bad_spec_o  = (spec_state_q == BAD);

  // ##########################################################
  // PC, stalls and speculation
  // ##########################################################
  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q         <= `PC_INIT;
      stall_q      <= 1'b0;
      refilling_q  <= 1'b0;
      fence_pend_q <= 1'b0;
      btb_valid_q  <= 1'b0;
      spec_state_q <= NONE;
    end else begin
      if (refill_start_o) begin
        refilling_q <= 1'b1;
      end else if (refill_done_i) begin
        refilling_q <= 1'b0;
      end

      // Hold fetch until the fence.i has left the output register.
      if (take_o && is_fence_i) begin
        fence_pend_q <= 1'b1;
      end else if (out_free_i) begin
        fence_pend_q <= 1'b0;
      end

      if (commit_i.change) begin
        btb_valid_q <= 1'b1;
      end

      case (spec_state_q)
        SPEC: begin
          if (commit_any) begin
            spec_state_q <= spec_match ? GOOD : BAD;
          end
        end
        GOOD, BAD: spec_state_q <= NONE;  // One cycle pulse.
        default: ;
      endcase

      if (spec_state_q == BAD) begin
        pc_q    <= redirect_q;
        stall_q <= 1'b0;  // Wrong path stall.
      end else if (stall_q && commit_any && (spec_state_q != SPEC)) begin
        stall_q <= 1'b0;
        pc_q    <= commit_i.change ? commit_i.target : pc_q + 32'd4;
      end else if (take_o) begin
        if (is_load) begin
          stall_q <= 1'b1;
        end else if (is_ctrl) begin
          if (btb_valid_q && (spec_state_q != SPEC)) begin
            pc_q         <= btb_q;
            spec_state_q <= SPEC;
          end else begin
            stall_q <= 1'b1;
          end
        end else begin
          pc_q <= pc_q + 32'd4;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (commit_i.change) begin
      btb_q <= commit_i.target;
    end
    if (take_o && is_ctrl && btb_valid_q && (spec_state_q != SPEC)) begin
      spec_target_q <= btb_q;
    end
    if ((spec_state_q == SPEC) && commit_any) begin
      redirect_q <= resolved_pc;
    end
  end

  a_spec_resolve: assert property (@(posedge clk) disable iff (rst)
    (spec_state_q == SPEC) && commit_any |=> (good_spec_o != bad_spec_o));

endmodule

`default_nettype wire

//--- logic/fetch_out.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defines.svh"

module fetch_out
  import fetch_bus_pkg::*;
(
  input  logic          clk,
  input  logic          rst,
  input  logic          take_i,
  input  fetch_bundle_t take_bundle_i,
  input  logic          flush_i,
  output logic          free_o,
  output logic          invalidate_o,
  output fetch_bundle_t out_o,
  output logic          out_valid_o,
  input  logic          out_ready_i
);

  logic          valid_q;
  fetch_bundle_t bundle_q;

  assign out_o        = bundle_q;
  assign out_valid_o  = valid_q && !flush_i;  // Flush drops the held bundle at once.
  assign free_o       = !valid_q || out_ready_i;
  assign invalidate_o = out_valid_o && out_ready_i && (bundle_q.inst == `INST_FENCE_I);

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (take_i) begin
      valid_q <= 1'b1;
    end else if (flush_i || out_ready_i) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (take_i) begin
      bundle_q <= take_bundle_i;
    end
  end

  a_hold_stable: assert property (@(posedge clk) disable iff (rst)
    out_valid_o && !out_ready_i |=> flush_i || (out_valid_o && $stable(out_o)));

endmodule

`default_nettype wire

//--- logic/fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_top
  import fetch_types_pkg::*;
  import fetch_bus_pkg::*;
(
  input  logic          clk,
  input  logic          rst,
  output mem_req_t      mem_req_o,
  input  mem_resp_t     mem_resp_i,
  input  commit_t       commit_i,
  output fetch_bundle_t out_o,
  output logic          out_valid_o,
  input  logic          out_ready_i,
  output logic          spec_o,
  output logic          good_spec_o,
  output logic          bad_spec_o
);

  logic          hit;
  inst_t         rd_inst;
  logic          refill_start;
  addr_t         refill_pc;
  logic          refill_done;
  line_wr_t      line_wr;
  addr_t         lookup_pc;
  logic          take;
  fetch_bundle_t take_bundle;
  logic          out_free;
  logic          invalidate;

  // ##########################################################
  // Input side, cache and fetch control, output register
  // ##########################################################
  l1i_refill refill_i (
    .clk, .rst,
    .refill_start_i(refill_start), .refill_pc_i(refill_pc),
    .mem_req_o, .mem_resp_i,
    .line_wr_o(line_wr), .refill_done_o(refill_done)
  );

  l1i_array array_i (
    .clk, .rst,
    .lookup_pc_i(lookup_pc), .hit_o(hit), .rd_inst_o(rd_inst),
    .line_wr_i(line_wr), .invalidate_i(invalidate)
  );

  fetch_ctrl ctrl_i (
    .clk, .rst,
    .hit_i(hit), .rd_inst_i(rd_inst),
    .refill_start_o(refill_start), .refill_pc_o(refill_pc), .refill_done_i(refill_done),
    .lookup_pc_o(lookup_pc),
    .take_o(take), .take_bundle_o(take_bundle), .out_free_i(out_free),
    .commit_i, .spec_o, .good_spec_o, .bad_spec_o
  );

  fetch_out out_i (
    .clk, .rst,
    .take_i(take), .take_bundle_i(take_bundle),
    .flush_i(bad_spec_o),  // Cancelled speculation.
    .free_o(out_free), .invalidate_o(invalidate),
    .out_o, .out_valid_o, .out_ready_i
  );

endmodule

`default_nettype wire

//--- testbench/fetch_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defines.svh"

module fetch_mem_model
  import fetch_types_pkg::*;
  import fetch_bus_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic [1:0] delay_i,
  input  mem_req_t   mem_req_i,
  output mem_resp_t  mem_resp_o,
  input  addr_t      peek_addr_i,
  output inst_t      peek_data_o
);

  logic [1:0] wait_q;

  function automatic inst_t image_word(input addr_t a);
    logic [11:0] imm;
    imm = a[13:2] ^ a[25:14] ^ {6'd0, a[31:26]};
    case (a - `PC_INIT)
      32'h0c:  return 32'h0000_a103;  // lw x2, 0(x1).
      32'h14:  return 32'h00c0_006f;  // jal x0, +12.
      32'h34:  return 32'hfe00_06e3;  // beq x0, x0, -20.
      32'h3c:  return `INST_FENCE_I;
      32'h44:  return 32'hfc00_0ee3;  // beq x0, x0, -36.
      default: return {imm, 5'd1, 3'b000, 5'd1, 7'b0010011};  // addi x1, x1, imm.
    endcase
  endfunction

  assign peek_data_o = image_word(peek_addr_i);

  initial begin
    mem_resp_o = '0;
  end

  // One response pulse per request level, after a random wait.
  always @(posedge clk) begin
    if (rst) begin
      mem_resp_o <= '0;
      wait_q     <= '0;
    end else begin
      mem_resp_o.valid <= 1'b0;
      if (mem_req_i.valid && !mem_resp_o.valid) begin
        if (wait_q == 2'd0) begin
          mem_resp_o.valid <= 1'b1;
          mem_resp_o.data  <= image_word(mem_req_i.addr);
          wait_q           <= delay_i;
        end else begin
          wait_q <= wait_q - 2'd1;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- testbench/fetch_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defines.svh"

module fetch_tb
  import fetch_types_pkg::*;
  import fetch_bus_pkg::*;
#(
  parameter logic [31:0] SEED = 32'h456b
);

  localparam int CLK_PERIOD = 40;
  localparam int MAX_CYCLES = 4000;

  logic clk, rst, out_ready, out_valid, spec, good_spec, bad_spec;
  mem_req_t      mem_req;
  mem_resp_t     mem_resp;
  commit_t       commit;
  fetch_bundle_t out;
  logic [1:0]    mem_delay;
  inst_t         image_word;
  logic [31:0]   lfsr_q;

  // Expected fetch flow.
  addr_t   exp_pc_q, redirect_q, btb_q, pend_pc_q;
  commit_t pend_commit_q;
  logic    hold_q, spec_q, btb_valid_q, good_due_q, bad_due_q, fence_seen_q, req_prev_q;
  logic    end_seen_q;
  logic [2:0] hold_cnt_q;
  int      br_hits_q, good_n_q, bad_n_q, refetch_n_q;
  logic [`L1I_SETS-1:0] sh_valid_q;  // Cache contents as the bus traffic implies.
  tag_t    sh_tag_q [`L1I_SETS][`L1I_LINE_WORDS];

  logic xfer, out_is_load, out_is_ctrl, req_new;

  assign xfer        = out_valid && out_ready;
  assign out_is_load = (out.inst[6:0] == `OP_LOAD);
  assign out_is_ctrl = (out.inst[6:0] == `OP_JAL) || (out.inst[6:0] == `OP_JALR) ||
                       (out.inst[6:0] == `OP_BRANCH) || (out.inst[6:0] == `OP_SYSTEM);
  assign req_new     = mem_req.valid && !req_prev_q;

  fetch_top dut_i (
    .clk, .rst,
    .mem_req_o(mem_req), .mem_resp_i(mem_resp), .commit_i(commit),
    .out_o(out), .out_valid_o(out_valid), .out_ready_i(out_ready),
    .spec_o(spec), .good_spec_o(good_spec), .bad_spec_o(bad_spec)
  );

  fetch_mem_model mem_i (
    .clk, .rst, .delay_i(mem_delay), .mem_req_i(mem_req), .mem_resp_o(mem_resp),
    .peek_addr_i(out.pc), .peek_data_o(image_word)
  );

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic word_cached(input addr_t a, input logic whole_line);
    idx_t idx;
    tag_t tag;
    idx = a[`L1I_OFS_W+2 +: `L1I_IDX_W];
    tag = a[31 -: $bits(tag_t)];
    if (whole_line) begin
      return sh_valid_q[idx] && (sh_tag_q[idx][0] == tag) && (sh_tag_q[idx][1] == tag);
    end
    return sh_valid_q[idx] && (sh_tag_q[idx][a[2]] == tag);
  endfunction

  task automatic report_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    $display("FAIL at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    $display("Simulation FAILED");
    $fatal(1, "value mismatch");
  endtask

  task automatic report_error(input string what);
    $display("Error at %0t ns: %s", $time, what);
    $display("Simulation FAILED");
    $fatal(1, "check failed");
  endtask

  task automatic finish_run();
    if ((good_n_q == 2) && (bad_n_q == 1) && (refetch_n_q > 0)) begin
      $display("Simulation PASSED");
      $finish;
    end else begin
      report_error("the run ended before every speculation and refetch case was seen");
    end
  endtask

  // ##########################################################
  // Clock, reset, stimulus and watchdog
  // ##########################################################
  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    rst       = 1'b1;
    out_ready = 1'b0;
    mem_delay = 2'd0;
    commit    = '0;
    lfsr_q    = SEED;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
  end

  initial begin
    #(MAX_CYCLES * CLK_PERIOD);
    report_error("watchdog timeout, fetch stopped making progress");
  end

  initial begin
    wait (end_seen_q);
    @(negedge clk);
    finish_run();
  end

  always @(posedge clk) begin
    logic [31:0] s;
    s = lfsr_next(lfsr_q);
    out_ready <= s[0];
    s = lfsr_next(s);
    mem_delay[0] <= s[0];
    s = lfsr_next(s);
    mem_delay[1] <= s[0];
    lfsr_q = s;
  end

  // ##########################################################
  // Reference model and commit generation
  // ##########################################################
  always @(posedge clk) begin
    commit_t c;
    logic    use_retire;
    addr_t   resolved;
    if (rst) begin
      exp_pc_q <= `PC_INIT;
      {hold_q, spec_q, btb_valid_q, good_due_q, bad_due_q, fence_seen_q} <= '0;
      req_prev_q  <= 1'b0;
      end_seen_q  <= 1'b0;
      hold_cnt_q  <= '0;
      br_hits_q   <= 0;
      good_n_q    <= 0;
      bad_n_q     <= 0;
      refetch_n_q <= 0;
      sh_valid_q  <= '0;
      commit      <= '0;
    end else begin
      commit     <= '0;
      good_due_q <= 1'b0;
      bad_due_q  <= 1'b0;
      req_prev_q <= mem_req.valid;
      if (req_new && fence_seen_q && (mem_req.addr == `PC_INIT + 32'h28)) begin
        refetch_n_q <= refetch_n_q + 1;
      end
      if (mem_resp.valid) begin
        sh_tag_q[mem_req.addr[4:3]][mem_req.addr[2]] <= mem_req.addr[31 -: $bits(tag_t)];
        if (mem_req.addr[2]) sh_valid_q[mem_req.addr[4:3]] <= 1'b1;  // Last word.
      end
      if (hold_q) begin
        hold_cnt_q <= hold_cnt_q - 3'd1;
        if (hold_cnt_q == 3'd0) begin
          commit   <= pend_commit_q;
          hold_q   <= 1'b0;
          exp_pc_q <= pend_pc_q;
          if (pend_commit_q.change) begin
            btb_q       <= pend_commit_q.target;
            btb_valid_q <= 1'b1;
          end
        end
      end
      if (xfer) begin
        if (out.inst == `INST_FENCE_I) begin
          fence_seen_q <= 1'b1;
          sh_valid_q   <= '0;
        end
        if (fence_seen_q && (out.pc == `PC_INIT + 32'h2c)) end_seen_q <= 1'b1;
        if (out_is_load || out_is_ctrl) begin
          use_retire = out_is_load || ((out.pc == `PC_INIT + 32'h34) && (br_hits_q == 1));
          c.change   = !use_retire;
          c.retire   = use_retire;
          c.target   = `PC_INIT + 32'h20;
          c.pc       = out.pc;
          resolved   = use_retire ? out.pc + 32'd4 : c.target;
          if (out.pc == `PC_INIT + 32'h34) br_hits_q <= br_hits_q + 1;
          if (out_is_ctrl && btb_valid_q && !spec_q) begin
            spec_q   <= 1'b1;  // Fetch goes on at the held target.
            exp_pc_q <= btb_q;
            commit   <= c;
            if (c.change) btb_q <= c.target;
            if (resolved == btb_q) begin
              good_due_q <= 1'b1;
            end else begin
              bad_due_q  <= 1'b1;
              redirect_q <= resolved;
            end
          end else begin
            hold_q        <= 1'b1;
            hold_cnt_q    <= 3'd4;
            pend_commit_q <= c;
            pend_pc_q     <= resolved;
          end
        end else begin
          exp_pc_q <= out.pc + 32'd4;
        end
      end
      if (good_spec) begin
        spec_q   <= 1'b0;
        good_n_q <= good_n_q + 1;
      end
      if (bad_spec) begin
        spec_q   <= 1'b0;
        bad_n_q  <= bad_n_q + 1;
        exp_pc_q <= redirect_q;
      end
    end
  end

  // ##########################################################
  // Checks
  // ##########################################################
  a_reset_low: assert property (@(posedge clk)
    rst |=> !mem_req.valid && !out_valid && !spec && !good_spec && !bad_spec)
    else report_error("an output was high right after reset");

  a_pc: assert property (@(posedge clk) disable iff (rst) xfer |-> out.pc == exp_pc_q)
    else report_value("out_o.pc", $sampled(out.pc), $sampled(exp_pc_q));

  a_inst: assert property (@(posedge clk) disable iff (rst) xfer |-> out.inst == image_word)
    else report_value("out_o.inst", $sampled(out.inst), $sampled(image_word));

  a_stall: assert property (@(posedge clk) disable iff (rst) hold_q |-> !out_valid)
    else report_error("a bundle came out while a load or jump was unresolved");

  a_stable: assert property (@(posedge clk) disable iff (rst)
    out_valid && !out_ready |=> bad_spec || (out_valid && $stable(out)))
    else report_error("the output bundle changed while it was held");

  a_spec_up: assert property (@(posedge clk) disable iff (rst)
    xfer && out_is_ctrl && btb_valid_q && !spec_q |-> spec)
    else report_error("spec_o stayed low on a branch with a held target");

  a_good: assert property (@(posedge clk) disable iff (rst)
    good_due_q |=> good_spec && !bad_spec)
    else report_error("a matching commit gave no good_spec_o pulse");

  a_bad: assert property (@(posedge clk) disable iff (rst)
    bad_due_q |=> bad_spec && !good_spec)
    else report_error("a mismatching commit gave no bad_spec_o pulse");

  a_bad_drop: assert property (@(posedge clk) disable iff (rst) bad_spec |-> !out_valid)
    else report_error("a wrong path bundle was offered during bad_spec_o");

  a_no_refetch: assert property (@(posedge clk) disable iff (rst)
    req_new && !mem_req.addr[2] |-> !word_cached(mem_req.addr, 1'b1))
    else report_error("the bus was asked again for a line that was still cached");

  a_cached: assert property (@(posedge clk) disable iff (rst)
    xfer |-> word_cached(out.pc, 1'b0))
    else report_error("a bundle came out of a line that was never refilled");

endmodule

`default_nettype wire

//--- src.f
+incdir+logic
logic/fetch_types_pkg.sv
logic/fetch_bus_pkg.sv
logic/l1i_refill.sv
logic/l1i_array.sv
logic/fetch_ctrl.sv
logic/fetch_out.sv
logic/fetch_top.sv
testbench/fetch_mem_model.sv
testbench/fetch_tb.sv

//--- Makefile
# Verilator build and run for the fetch stage testbench.

VERILATOR ?= verilator
TOP       ?= fetch_tb
LOG       ?= sim.log
SEED      ?= 17771
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GSEED=$(SEED) -Mdir $(BUILD_DIR) -f src.f

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^Simulation PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
